/* Makefile */
VERILATOR  = verilator
TOP        = mesh_router_tb
RTL_TOP    = mesh_router
FILELIST   = src.f
LINT_FLAGS = --lint-only --timing
SIM_FLAGS  = --binary --timing --assert
OBJ_DIR    = obj_dir
SIM_BIN    = $(OBJ_DIR)/V$(TOP)
PASS_MSG   = Simulation completed successfully

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

$(SIM_BIN): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

sim: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* design/flit_queue.sv */
`timescale 1ns/1ps

module flit_queue #(
    parameter int  QUEUE_DEPTH = 4,
    parameter type payload_t   = logic [31:0]
) (
    input  logic     clk,
    input  logic     rst,
    input  payload_t in_data,
    input  logic     in_valid,
    output logic     in_ready,
    output payload_t out_data,
    output logic     out_valid,
    input  logic     out_ready
);

    // pointer and occupancy widths
    localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

    payload_t         mem [QUEUE_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             wr_en;
    logic             rd_en;

    // handshakes on both sides
    assign wr_en = in_valid && in_ready;
    assign rd_en = out_valid && out_ready;

    // only back-pressure when every entry is taken
    assign in_ready  = (count != CNT_W'(QUEUE_DEPTH));
    // head is visible the cycle after it was written
    assign out_valid = (count != '0);
    assign out_data  = mem[rd_ptr];

    // storage, no reset needed
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= in_data;
        end
    end

    // pointers wrap at the depth, which need not be a power of two
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= (wr_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= (rd_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // simultaneous push and pop leaves count alone
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

/* design/inject_merge.sv */
`timescale 1ns/1ps

module inject_merge (
    input  router_pkg::flit_t [1:0] sw_flits,
    input  logic [1:0]              sw_valid,
    output logic [1:0]              sw_ready,
    input  router_pkg::flit_t [1:0] inject_flits,
    input  logic [1:0]              inject_valid,
    output logic [1:0]              inject_ready,
    output router_pkg::flit_t [1:0] out_flits,
    output logic [1:0]              out_valid,
    input  logic [1:0]              out_ready
);

    ////////////////////////////////////////////////////////////
    // per network output mux

    // index 0 is the x link, index 1 the y link
    // an injected flit always wins the link
    always_comb begin
        for (int n = 0; n < 2; n++) begin
            if (inject_valid[n]) begin
                out_flits[n] = inject_flits[n];
            end else begin
                out_flits[n] = sw_flits[n];
            end
            out_valid[n] = inject_valid[n] | sw_valid[n];
        end
    end

    ////////////////////////////////////////////////////////////
    // ready back to both sources

    // injector sees the link directly
    assign inject_ready = out_ready;

    // switch slot stalls while an inject is pending
    // its flit stays put in the slot
    assign sw_ready = out_ready & ~inject_valid;

endmodule

/* design/mesh_router.sv */
`timescale 1ns/1ps

module mesh_router #(
    parameter router_pkg::coord_t cur_x       = '0,
    parameter router_pkg::coord_t cur_y       = '0,
    parameter int                 QUEUE_DEPTH = 4
) (
    input  logic                                        clk,
    input  logic                                        rst,
    // network inputs
    input  router_pkg::flit_t [router_pkg::NUM_IN-1:0]  in_flits,
    input  logic [router_pkg::NUM_IN-1:0]               in_valid,
    output logic [router_pkg::NUM_IN-1:0]               in_ready,
    // local injection onto x and y
    input  router_pkg::flit_t [1:0]                     inject_flits,
    input  logic [1:0]                                  inject_valid,
    output logic [1:0]                                  inject_ready,
    // network outputs
    output router_pkg::flit_t [1:0]                     out_flits,
    output logic [1:0]                                  out_valid,
    input  logic [1:0]                                  out_ready,
    // local eject
    output router_pkg::flit_t                           eject_flit,
    output logic                                        eject_valid,
    input  logic                                        eject_ready
);

    import router_pkg::*;

    // queue to route stage
    flit_t        [NUM_IN-1:0]  q_flits;
    logic         [NUM_IN-1:0]  q_valid;
    logic         [NUM_IN-1:0]  q_ready;

    // route stage to switch
    routed_flit_t [NUM_IN-1:0]  rc_flits;
    logic         [NUM_IN-1:0]  rc_valid;
    logic         [NUM_IN-1:0]  rc_ready;

    // switch slots, indexed by OUT_X / OUT_Y / OUT_EJECT
    flit_t        [NUM_OUT-1:0] sw_flits;
    logic         [NUM_OUT-1:0] sw_valid;
    wire          [NUM_OUT-1:0] sw_ready;

    ////////////////////////////////////////////////////////////
    // per input: queue then route stage

    for (genvar g = 0; g < NUM_IN; g++) begin : g_in
        flit_queue #(
            .QUEUE_DEPTH (QUEUE_DEPTH),
            .payload_t   (flit_t)
        ) input_queue (
            .clk       (clk),
            .rst       (rst),
            .in_data   (in_flits[g]),
            .in_valid  (in_valid[g]),
            .in_ready  (in_ready[g]),
            .out_data  (q_flits[g]),
            .out_valid (q_valid[g]),
            .out_ready (q_ready[g])
        );

        route_compute #(
            .cur_x (cur_x),
            .cur_y (cur_y)
        ) route_stage (
            .clk       (clk),
            .rst       (rst),
            .in_flit   (q_flits[g]),
            .in_valid  (q_valid[g]),
            .in_ready  (q_ready[g]),
            .out_flit  (rc_flits[g]),
            .out_valid (rc_valid[g]),
            .out_ready (rc_ready[g])
        );
    end

    ////////////////////////////////////////////////////////////
    // switch and output side

    switch_alloc switch_inst (
        .clk       (clk),
        .rst       (rst),
        .in_flits  (rc_flits),
        .in_valid  (rc_valid),
        .in_ready  (rc_ready),
        .out_flits (sw_flits),
        .out_valid (sw_valid),
        .out_ready (sw_ready)
    );

    // x and y slots pass through the inject mux
    inject_merge merge_inst (
        .sw_flits     (sw_flits[OUT_Y:OUT_X]),
        .sw_valid     (sw_valid[OUT_Y:OUT_X]),
        .sw_ready     (sw_ready[OUT_Y:OUT_X]),
        .inject_flits (inject_flits),
        .inject_valid (inject_valid),
        .inject_ready (inject_ready),
        .out_flits    (out_flits),
        .out_valid    (out_valid),
        .out_ready    (out_ready)
    );

    // eject slot goes straight to the local port
    assign eject_flit         = sw_flits[OUT_EJECT];
    assign eject_valid        = sw_valid[OUT_EJECT];
    assign sw_ready[OUT_EJECT] = eject_ready;

endmodule

/* design/route_compute.sv */
`timescale 1ns/1ps

module route_compute #(
    parameter router_pkg::coord_t cur_x = '0,
    parameter router_pkg::coord_t cur_y = '0
) (
    input  logic                     clk,
    input  logic                     rst,
    input  router_pkg::flit_t        in_flit,
    input  logic                     in_valid,
    output logic                     in_ready,
    output router_pkg::routed_flit_t out_flit,
    output logic                     out_valid,
    input  logic                     out_ready
);

    import router_pkg::*;

    out_sel_t sel_next;
    logic     load;

    ////////////////////////////////////////////////////////////
    // dimension-order routing

    // x is resolved first, then y
    // only a flit already at this node in both axes is ejected
    always_comb begin
        if (in_flit.dst_x != cur_x) begin
            sel_next = OUT_X;
        end else if (in_flit.dst_y != cur_y) begin
            sel_next = OUT_Y;
        end else begin
            sel_next = OUT_EJECT;
        end
    end

    ////////////////////////////////////////////////////////////
    // pipeline register

    // stage frees up when empty or when its flit leaves this cycle
    assign in_ready = !out_valid || out_ready;
    assign load     = in_valid && in_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else if (in_ready) begin
            // refill or drain
            out_valid <= in_valid;
        end
    end

    // flit and its output choice
    always_ff @(posedge clk) begin
        if (load) begin
            out_flit.flit    <= in_flit;
            out_flit.out_sel <= sel_next;
        end
    end

endmodule

/* design/router_pkg.sv */
package router_pkg;

    ////////////////////////////////////////////////////////////
    // mesh coordinates

    // three bits per axis, up to an 8x8 mesh
    localparam int COORD_W = 3;

    typedef logic [COORD_W-1:0] coord_t;

    ////////////////////////////////////////////////////////////
    // flit format

    // whatever is left of a 32-bit flit after the destination
    localparam int PAYLOAD_W = 26;

    // destination sits in the top bits, payload is opaque to the router
    typedef struct packed {
        coord_t                 dst_x;
        coord_t                 dst_y;
        logic [PAYLOAD_W-1:0]   payload;
    } flit_t;

    ////////////////////////////////////////////////////////////
    // ports

    // network inputs, x and y
    localparam int NUM_IN = 2;

    // network outputs x and y plus the local eject
    localparam int NUM_OUT = 3;

    typedef logic [1:0] out_sel_t;

    // output indices, also the bit order of the switch output vectors
    localparam out_sel_t OUT_X     = 2'd0;
    localparam out_sel_t OUT_Y     = 2'd1;
    localparam out_sel_t OUT_EJECT = 2'd2;

    // flit tagged with the output picked by route computation
    typedef struct packed {
        flit_t      flit;
        out_sel_t   out_sel;
    } routed_flit_t;

endpackage

/* design/switch_alloc.sv */
`timescale 1ns/1ps

module switch_alloc (
    input  logic                                            clk,
    input  logic                                            rst,
    input  router_pkg::routed_flit_t [router_pkg::NUM_IN-1:0] in_flits,
    input  logic [router_pkg::NUM_IN-1:0]                   in_valid,
    output logic [router_pkg::NUM_IN-1:0]                   in_ready,
    output router_pkg::flit_t [router_pkg::NUM_OUT-1:0]     out_flits,
    output logic [router_pkg::NUM_OUT-1:0]                  out_valid,
    input  logic [router_pkg::NUM_OUT-1:0]                  out_ready
);

    import router_pkg::*;

    // request matrix, one row per output
    logic [NUM_OUT-1:0][NUM_IN-1:0] req;
    logic [NUM_OUT-1:0][NUM_IN-1:0] gnt;

    // per-output arbitration state
    logic [NUM_OUT-1:0] slot_free;
    logic [NUM_OUT-1:0] contested;
    logic [NUM_OUT-1:0] win_idx;
    logic [NUM_OUT-1:0] grant_any;
    // favoured input for the next tie
    logic [NUM_OUT-1:0] rr_ptr;

    ////////////////////////////////////////////////////////////
    // arbitration

    // slot can take a flit when empty or emptying this cycle
    assign slot_free = ~out_valid | out_ready;

    always_comb begin
        for (int o = 0; o < NUM_OUT; o++) begin
            for (int i = 0; i < NUM_IN; i++) begin
                req[o][i] = in_valid[i] && (in_flits[i].out_sel == out_sel_t'(o));
            end
            // two-input round robin
            contested[o] = &req[o];
            // uncontested: whichever input asks
            win_idx[o]   = contested[o] ? rr_ptr[o] : req[o][1];
            grant_any[o] = (|req[o]) && slot_free[o];
            for (int i = 0; i < NUM_IN; i++) begin
                gnt[o][i] = grant_any[o] && (win_idx[o] == 1'(i));
            end
        end
    end

    // each input asks for one output, so at most one grant per column
    always_comb begin
        in_ready = '0;
        for (int o = 0; o < NUM_OUT; o++) begin
            for (int i = 0; i < NUM_IN; i++) begin
                in_ready[i] = in_ready[i] | gnt[o][i];
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // output slots

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= '0;
            rr_ptr    <= '0;
        end else begin
            for (int o = 0; o < NUM_OUT; o++) begin
                if (grant_any[o]) begin
                    out_valid[o] <= 1'b1;
                    // loser of a tie goes first next time
                    if (contested[o]) begin
                        rr_ptr[o] <= ~rr_ptr[o];
                    end
                end else if (out_ready[o]) begin
                    out_valid[o] <= 1'b0;
                end
            end
        end
    end

    // crossbar into the slot registers
    always_ff @(posedge clk) begin
        for (int o = 0; o < NUM_OUT; o++) begin
            if (grant_any[o]) begin
                out_flits[o] <= in_flits[win_idx[o]].flit;
            end
        end
    end

endmodule

/* src.f */
design/router_pkg.sv
design/flit_queue.sv
design/route_compute.sv
design/switch_alloc.sv
design/inject_merge.sv
design/mesh_router.sv
tests/mesh_router_tb.sv

/* tests/mesh_router_tb.sv */
`timescale 1ns/1ps

module mesh_router_tb;

    import router_pkg::*;

    localparam coord_t CUR_X   = 3'd2;
    localparam coord_t CUR_Y   = 3'd3;
    localparam int     MAX_VEC = 64;

    // flit and the output it has to leave on
    typedef struct packed {
        flit_t    flit;
        out_sel_t port;
    } expect_t;

    logic               clk = 1'b0;
    logic               rst;
    flit_t [NUM_IN-1:0] in_flits;
    logic  [NUM_IN-1:0] in_valid;
    logic  [NUM_IN-1:0] in_ready;
    flit_t [1:0]        inject_flits;
    logic  [1:0]        inject_valid;
    logic  [1:0]        inject_ready;
    flit_t [1:0]        out_flits;
    logic  [1:0]        out_valid;
    logic  [1:0]        out_ready;
    flit_t              eject_flit;
    logic               eject_valid;
    logic               eject_ready;

    // five words per vector holding test source dst_x dst_y and tag
    logic [15:0] vec_mem [MAX_VEC*5];
    int          num_vec;
    // flits not yet accepted and flits not yet delivered
    flit_t       send_q [$];
    expect_t     exp_q [$];
    logic [31:0] lfsr = 32'h6811;
    int          cycle_count = 0;
    int          cycle_limit = 200;
    logic        stall_seen;

    mesh_router #(.cur_x(CUR_X), .cur_y(CUR_Y), .QUEUE_DEPTH(4)) mesh_router_inst (.*);

    always #10 clk = ~clk;

    ////////////////////////////////////////////////////////////
    // helpers

    task automatic fail_now(input string line);
        $display("%s", line);
        $display("Simulation failed");
        $fatal(1);
    endtask

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return (s >> 1) ^ (s[0] ? 32'h80200003 : 32'h0);
    endfunction

    // one step per bit handed out
    function automatic logic take_bit();
        lfsr = lfsr_step(lfsr);
        return lfsr[0];
    endfunction

    // payload[17:16] holds the source with 0/1 for network x/y and 2/3 for inject x/y
    function automatic out_sel_t route_of(input flit_t f);
        // injected flits stay on their own link
        if (f.payload[17]) begin
            return out_sel_t'(f.payload[16]);
        end
        if (f.dst_x != CUR_X) begin
            return OUT_X;
        end
        if (f.dst_y != CUR_Y) begin
            return OUT_Y;
        end
        return OUT_EJECT;
    endfunction

    function automatic int find_send(input int key);
        for (int i = 0; i < send_q.size(); i++) begin
            if (int'(send_q[i].payload[17:16]) == key) begin
                return i;
            end
        end
        return -1;
    endfunction

    // oldest pending flit of one source on one output
    function automatic int find_expect(input logic [1:0] key, input out_sel_t port);
        for (int i = 0; i < exp_q.size(); i++) begin
            if (exp_q[i].flit.payload[17:16] == key && exp_q[i].port == port) begin
                return i;
            end
        end
        return -1;
    endfunction

    ////////////////////////////////////////////////////////////
    // stimulus and scoreboard

    task automatic load_test(input int test);
        flit_t   f;
        expect_t e;
        for (int v = 0; v < num_vec; v++) begin
            if (vec_mem[v*5] == 16'(test)) begin
                f.dst_x   = coord_t'(vec_mem[v*5+2]);
                f.dst_y   = coord_t'(vec_mem[v*5+3]);
                f.payload = {8'h00, vec_mem[v*5+1][1:0], vec_mem[v*5+4]};
                e.flit    = f;
                e.port    = route_of(f);
                send_q.push_back(f);
                exp_q.push_back(e);
            end
        end
    endtask

    // called on the falling edge
    task automatic drive_inputs(input int test);
        int idx;
        for (int s = 0; s < NUM_IN; s++) begin
            idx         = find_send(s);
            in_valid[s] = (idx >= 0);
            in_flits[s] = (idx >= 0) ? send_q[idx] : '0;
        end
        // inject valid stays up as long as that injector has flits
        for (int n = 0; n < 2; n++) begin
            idx             = find_send(n + 2);
            inject_valid[n] = (idx >= 0);
            inject_flits[n] = (idx >= 0) ? send_q[idx] : '0;
        end
        if (test == 5) begin
            // everything blocked until the inputs back up
            out_ready   = {2{stall_seen}};
            eject_ready = stall_seen;
        end else if (test >= 3) begin
            out_ready[0] = take_bit();
            out_ready[1] = take_bit();
            eject_ready  = take_bit();
        end else begin
            out_ready   = 2'b11;
            eject_ready = 1'b1;
        end
    endtask

    task automatic check_delivery(input flit_t got, input out_sel_t port);
        int idx;
        idx = find_expect(got.payload[17:16], port);
        assert (idx >= 0)
            else fail_now($sformatf("ERROR %0t: unexpected flit %h on output %0d",
                                    $time, got, port));
        if (idx >= 0) begin
            assert (exp_q[idx].flit == got)
                else fail_now($sformatf("ERROR %0t: output %0d got %h, expected %h",
                                        $time, port, got, exp_q[idx].flit));
            exp_q.delete(idx);
        end
    endtask

    // handshakes that complete at the coming rising edge
    task automatic sample_cycle();
        for (int s = 0; s < NUM_IN; s++) begin
            if (in_valid[s] && in_ready[s]) begin
                send_q.delete(find_send(s));
            end
            if (in_valid[s] && !in_ready[s]) begin
                stall_seen = 1'b1;
            end
        end
        for (int n = 0; n < 2; n++) begin
            if (inject_valid[n] && inject_ready[n]) begin
                send_q.delete(find_send(n + 2));
            end
            if (out_valid[n] && out_ready[n]) begin
                assert (!inject_valid[n] || out_flits[n].payload[17])
                    else fail_now($sformatf("ERROR %0t: switched flit on output %0d during inject",
                                            $time, n));
                check_delivery(out_flits[n], out_sel_t'(n));
            end
        end
        if (eject_valid && eject_ready) begin
            check_delivery(eject_flit, OUT_EJECT);
        end
    endtask

    task automatic run_test(input int test);
        int waited;
        waited     = 0;
        stall_seen = 1'b0;
        load_test(test);
        while (send_q.size() != 0 || exp_q.size() != 0) begin
            @(negedge clk);
            drive_inputs(test);
            #1;
            sample_cycle();
            if (test == 5 && !stall_seen) begin
                waited++;
                assert (waited < 40)
                    else fail_now("in_ready never fell while every output was blocked");
            end
        end
    endtask

    ////////////////////////////////////////////////////////////
    // run

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            fail_now($sformatf("timeout after %0d cycles with flits still in flight",
                               cycle_count));
        end
    end

    initial begin
        for (int i = 0; i < MAX_VEC*5; i++) begin
            vec_mem[i] = '0;
        end
        $readmemh("tests/router_vectors.mem", vec_mem);
        // test number zero ends the list
        num_vec = 0;
        while (num_vec < MAX_VEC && vec_mem[num_vec*5] != '0) begin
            num_vec++;
        end
        cycle_limit  = 40 * num_vec + 200;
        rst          = 1'b1;
        in_flits     = '0;
        in_valid     = '0;
        inject_flits = '0;
        inject_valid = '0;
        out_ready    = '0;
        eject_ready  = 1'b0;
        stall_seen   = 1'b0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        #1;
        assert (out_valid == '0 && eject_valid == 1'b0)
            else fail_now($sformatf("ERROR %0t: output valid high after reset", $time));
        assert (in_ready == '1)
            else fail_now($sformatf("ERROR %0t: in_ready low after reset", $time));
        for (int t = 1; t <= 5; t++) begin
            run_test(t);
        end
        // all outputs still ready, a duplicate would show up here
        repeat (8) begin
            @(negedge clk);
            #1;
            assert (out_valid == '0 && eject_valid == 1'b0)
                else fail_now($sformatf("ERROR %0t: extra flit at an output after the last delivery",
                                        $time));
        end
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

/* tests/router_vectors.mem */
// test source dst_x dst_y tag, node at x 2 y 3; source 0/1 network x/y, 2/3 inject x/y
// test 1 routing, 2 contention, 3 random ready, 4 inject with random ready, 5 all blocked
01 0 5 3 0101
01 1 2 6 0102
01 0 2 3 0103
01 1 0 0 0104
01 0 2 1 0105
01 1 2 3 0106
02 0 4 0 0201
02 1 7 7 0202
02 0 1 3 0203
02 1 3 2 0204
03 0 6 3 0301
03 1 2 0 0302
03 0 2 3 0303
03 1 5 5 0304
03 0 2 7 0305
03 1 2 3 0306
04 0 0 2 0401
04 1 6 1 0402
04 2 1 1 0403
04 2 3 3 0404
04 2 5 6 0405
04 2 7 0 0406
05 0 4 1 0501
05 0 0 3 0502
05 0 7 7 0503
05 0 1 0 0504
05 0 6 2 0505
05 0 3 3 0506
05 0 5 4 0507
